//--- src/rvPkg.sv
package rvPkg;

   // Data word or byte address
   typedef logic [31:0] word_t;

   // Register index x0..x31
   typedef logic [4:0] regAddr_t;

   // Major opcodes, instruction bits 6:0
   typedef enum logic [6:0] {
      opLoad   = 7'b0000011,
      opOpImm  = 7'b0010011,
      opAuipc  = 7'b0010111,
      opStore  = 7'b0100011,
      opOp     = 7'b0110011,
      opLui    = 7'b0110111,
      opBranch = 7'b1100011,
      opJalr   = 7'b1100111,
      opJal    = 7'b1101111
   } opcode_t;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluSll,
      aluSlt,
      aluSltu,
      aluXor,
      aluSrl,
      aluSra,
      aluOr,
      aluAnd,
      // B operand straight through, used by LUI
      aluPassB
   } aluOp_t;

   // Writeback source
   typedef enum logic [1:0] {
      resAlu,
      resMem,
      resLink
   } resultSel_t;

endpackage

//--- src/busPkg.sv
package busPkg;

   // One bit per byte lane of the data bus
   typedef logic [3:0] byteSel_t;

   // Access size, same code as funct3[1:0] of loads and stores
   typedef enum logic [1:0] {
      sizeByte = 2'd0,
      sizeHalf = 2'd1,
      sizeWord = 2'd2
   } memSize_t;

endpackage

//--- src/regFile.sv
`timescale 1ns/10ps

module regFile (
   input  logic            clk,
   input  logic            rst,
   input  rvPkg::regAddr_t rdAddrA,
   input  rvPkg::regAddr_t rdAddrB,
   output rvPkg::word_t    rdDataA,
   output rvPkg::word_t    rdDataB,
   input  logic            wrEnable,
   input  rvPkg::regAddr_t wrAddr,
   input  rvPkg::word_t    wrData
);
   import rvPkg::*;

   word_t regs [32];
   logic  doWrite;

   // x0 is never stored
   assign doWrite = wrEnable && !rst && (wrAddr != 5'd0);

   // Write-through so decode sees a value written this cycle
   assign rdDataA = (rdAddrA == 5'd0) ? '0 :
                    (doWrite && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (rdAddrB == 5'd0) ? '0 :
                    (doWrite && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

   always_ff @(posedge clk)
   begin
      if (doWrite)
      begin
         regs[wrAddr] <= wrData;
      end
   end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/10ps

module decodeStage #(
   parameter rvPkg::word_t resetAddr = 32'h0000_0000
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              stall,
   input  logic              redirect,
   input  rvPkg::word_t      redirectPc,
   output rvPkg::word_t      instrAddr,
   input  rvPkg::word_t      instrData,
   output rvPkg::regAddr_t   rdAddrA,
   output rvPkg::regAddr_t   rdAddrB,
   input  rvPkg::word_t      rdDataA,
   input  rvPkg::word_t      rdDataB,
   output logic              exValid,
   output rvPkg::word_t      exPc,
   output rvPkg::regAddr_t   exRs1,
   output rvPkg::regAddr_t   exRs2,
   output rvPkg::word_t      exRs1Data,
   output rvPkg::word_t      exRs2Data,
   output rvPkg::word_t      exImm,
   output rvPkg::aluOp_t     exAluOp,
   output logic              exUseImm,
   output logic              exUsePc,
   output rvPkg::resultSel_t exResultSel,
   output rvPkg::regAddr_t   exRd,
   output logic              exRegWrite,
   output logic              exIsBranch,
   output logic [2:0]        exBranchCond,
   output logic              exIsJal,
   output logic              exIsJalr,
   output logic              exMemRead,
   output logic              exMemWrite,
   output busPkg::memSize_t  exMemSize,
   output logic              exMemUnsigned
);
   import rvPkg::*;
   import busPkg::*;

   word_t      pc;
   word_t      decPc;
   logic       decValid;
   opcode_t    opcode;
   logic [2:0] funct3;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;
   logic       known;
   word_t      imm;
   aluOp_t     aluOp;
   logic       useImm;
   logic       usePc;
   resultSel_t resSel;
   logic       regWrite;
   logic       isBranch;
   logic       isJal;
   logic       isJalr;
   logic       memRead;
   logic       memWrite;

   function automatic aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
      aluOp_t op;
      case (f3)
         3'b000:  op = alt ? aluSub : aluAdd;
         3'b001:  op = aluSll;
         3'b010:  op = aluSlt;
         3'b011:  op = aluSltu;
         3'b100:  op = aluXor;
         3'b101:  op = alt ? aluSra : aluSrl;
         3'b110:  op = aluOr;
         default: op = aluAnd;
      endcase
      return op;
   endfunction

   // While stalled, re-present the address of the held instruction
   assign instrAddr = stall ? decPc : pc;

   assign opcode  = opcode_t'(instrData[6:0]);
   assign funct3  = instrData[14:12];
   assign rdAddrA = instrData[19:15];
   assign rdAddrB = instrData[24:20];

   assign immI = {{20{instrData[31]}}, instrData[31:20]};
   assign immS = {{20{instrData[31]}}, instrData[31:25], instrData[11:7]};
   assign immB = {{19{instrData[31]}}, instrData[31], instrData[7],
                  instrData[30:25], instrData[11:8], 1'b0};
   assign immU = {instrData[31:12], 12'b0};
   assign immJ = {{11{instrData[31]}}, instrData[31], instrData[19:12],
                  instrData[20], instrData[30:21], 1'b0};

   always_comb
   begin
      known    = 1'b1;
      imm      = immI;
      aluOp    = aluAdd;
      useImm   = 1'b1;
      usePc    = 1'b0;
      resSel   = resAlu;
      regWrite = 1'b1;
      isBranch = 1'b0;
      isJal    = 1'b0;
      isJalr   = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      case (opcode)
         opOp:
         begin
            useImm = 1'b0;
            aluOp  = aluFromFunct(funct3, instrData[30]);
         end
         // Only shifts look at bit 30 in the immediate form
         opOpImm: aluOp = aluFromFunct(funct3, funct3 == 3'b101 && instrData[30]);
         opLui:
         begin
            imm   = immU;
            aluOp = aluPassB;
         end
         opAuipc:
         begin
            imm   = immU;
            usePc = 1'b1;
         end
         opJal:
         begin
            imm    = immJ;
            isJal  = 1'b1;
            resSel = resLink;
         end
         opJalr:
         begin
            isJalr = 1'b1;
            resSel = resLink;
         end
         opBranch:
         begin
            imm      = immB;
            useImm   = 1'b0;
            isBranch = 1'b1;
            regWrite = 1'b0;
         end
         opLoad:
         begin
            memRead = 1'b1;
            resSel  = resMem;
         end
         opStore:
         begin
            imm      = immS;
            memWrite = 1'b1;
            regWrite = 1'b0;
         end
         default:
         begin
            known    = 1'b0;
            regWrite = 1'b0;
         end
      endcase
   end

   // PC and squash flags; a redirect kills decode and the fetch in flight
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc       <= resetAddr;
         decValid <= 1'b0;
         exValid  <= 1'b0;
      end
      else if (!stall)
      begin
         pc       <= redirect ? redirectPc : pc + 32'd4;
         decValid <= !redirect;
         exValid  <= decValid && known && !redirect;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         decPc         <= pc;
         exPc          <= decPc;
         exRs1         <= rdAddrA;
         exRs2         <= rdAddrB;
         exRs1Data     <= rdDataA;
         exRs2Data     <= rdDataB;
         exImm         <= imm;
         exAluOp       <= aluOp;
         exUseImm      <= useImm;
         exUsePc       <= usePc;
         exResultSel   <= resSel;
         exRd          <= instrData[11:7];
         exRegWrite    <= regWrite;
         exIsBranch    <= isBranch;
         exBranchCond  <= funct3;
         exIsJal       <= isJal;
         exIsJalr      <= isJalr;
         exMemRead     <= memRead;
         exMemWrite    <= memWrite;
         exMemSize     <= memSize_t'(funct3[1:0]);
         exMemUnsigned <= funct3[2];
      end
   end

endmodule

//--- src/executeStage.sv
`timescale 1ns/10ps

module executeStage (
   input  logic              clk,
   input  logic              rst,
   input  logic              stall,
   input  logic              exValid,
   input  rvPkg::word_t      exPc,
   input  rvPkg::regAddr_t   exRs1,
   input  rvPkg::regAddr_t   exRs2,
   input  rvPkg::word_t      exRs1Data,
   input  rvPkg::word_t      exRs2Data,
   input  rvPkg::word_t      exImm,
   input  rvPkg::aluOp_t     exAluOp,
   input  logic              exUseImm,
   input  logic              exUsePc,
   input  rvPkg::resultSel_t exResultSel,
   input  rvPkg::regAddr_t   exRd,
   input  logic              exRegWrite,
   input  logic              exIsBranch,
   input  logic [2:0]        exBranchCond,
   input  logic              exIsJal,
   input  logic              exIsJalr,
   input  logic              exMemRead,
   input  logic              exMemWrite,
   input  busPkg::memSize_t  exMemSize,
   input  logic              exMemUnsigned,
   input  logic              fwdValid,
   input  rvPkg::regAddr_t   fwdRd,
   input  rvPkg::word_t      fwdData,
   output logic              redirect,
   output rvPkg::word_t      redirectPc,
   output logic              rsValid,
   output rvPkg::regAddr_t   rsRd,
   output logic              rsRegWrite,
   output rvPkg::resultSel_t rsResultSel,
   output rvPkg::word_t      rsAlu,
   output rvPkg::word_t      rsLink,
   output logic              rsMemRead,
   output logic              rsMemWrite,
   output busPkg::memSize_t  rsMemSize,
   output logic              rsMemUnsigned,
   output rvPkg::word_t      rsStoreData,
   output busPkg::byteSel_t  rsByteSel
);
   import rvPkg::*;
   import busPkg::*;

   word_t    srcA;
   word_t    srcB;
   word_t    opA;
   word_t    opB;
   word_t    aluOut;
   logic     taken;
   word_t    storeData;
   byteSel_t byteSel;

   // Result-stage bypass; x0 is never forwarded
   assign srcA = (fwdValid && fwdRd != 5'd0 && fwdRd == exRs1) ? fwdData : exRs1Data;
   assign srcB = (fwdValid && fwdRd != 5'd0 && fwdRd == exRs2) ? fwdData : exRs2Data;

   assign opA = exUsePc ? exPc : srcA;
   assign opB = exUseImm ? exImm : srcB;

   always_comb
   begin
      case (exAluOp)
         aluAdd:   aluOut = opA + opB;
         aluSub:   aluOut = opA - opB;
         aluSll:   aluOut = opA << opB[4:0];
         aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
         aluSltu:  aluOut = {31'b0, opA < opB};
         aluXor:   aluOut = opA ^ opB;
         aluSrl:   aluOut = opA >> opB[4:0];
         aluSra:   aluOut = $signed(opA) >>> opB[4:0];
         aluOr:    aluOut = opA | opB;
         aluAnd:   aluOut = opA & opB;
         default:  aluOut = opB;
      endcase
   end

   // Branch compare on the forwarded register values
   always_comb
   begin
      case (exBranchCond)
         3'b000:  taken = srcA == srcB;
         3'b001:  taken = srcA != srcB;
         3'b100:  taken = $signed(srcA) < $signed(srcB);
         3'b101:  taken = $signed(srcA) >= $signed(srcB);
         3'b110:  taken = srcA < srcB;
         3'b111:  taken = srcA >= srcB;
         default: taken = 1'b0;
      endcase
   end

   assign redirect   = exValid && ((exIsBranch && taken) || exIsJal || exIsJalr);
   assign redirectPc = exIsJalr ? {aluOut[31:1], 1'b0} : exPc + exImm;

   // Replicate store data across lanes, select by size and address
   always_comb
   begin
      case (exMemSize)
         sizeByte:
         begin
            storeData = {4{srcB[7:0]}};
            byteSel   = 4'b0001 << aluOut[1:0];
         end
         sizeHalf:
         begin
            storeData = {2{srcB[15:0]}};
            byteSel   = aluOut[1] ? 4'b1100 : 4'b0011;
         end
         default:
         begin
            storeData = srcB;
            byteSel   = 4'b1111;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rsValid <= 1'b0;
      end
      else if (!stall)
      begin
         rsValid <= exValid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         rsRd          <= exRd;
         rsRegWrite    <= exRegWrite;
         rsResultSel   <= exResultSel;
         rsAlu         <= aluOut;
         rsLink        <= exPc + 32'd4;
         rsMemRead     <= exMemRead;
         rsMemWrite    <= exMemWrite;
         rsMemSize     <= exMemSize;
         rsMemUnsigned <= exMemUnsigned;
         rsStoreData   <= storeData;
         rsByteSel     <= byteSel;
      end
   end

endmodule

//--- src/resultStage.sv
`timescale 1ns/10ps

module resultStage (
   input  logic              clk,
   input  logic              rst,
   input  logic              rsValid,
   input  rvPkg::regAddr_t   rsRd,
   input  logic              rsRegWrite,
   input  rvPkg::resultSel_t rsResultSel,
   input  rvPkg::word_t      rsAlu,
   input  rvPkg::word_t      rsLink,
   input  logic              rsMemRead,
   input  logic              rsMemWrite,
   input  busPkg::memSize_t  rsMemSize,
   input  logic              rsMemUnsigned,
   input  rvPkg::word_t      rsStoreData,
   input  busPkg::byteSel_t  rsByteSel,
   output logic              stall,
   output logic              fwdValid,
   output rvPkg::regAddr_t   fwdRd,
   output rvPkg::word_t      fwdData,
   output logic              wrEnable,
   output rvPkg::regAddr_t   wrAddr,
   output rvPkg::word_t      wrData,
   output logic              wbCyc,
   output logic              wbStb,
   output logic              wbWe,
   output rvPkg::word_t      wbAdr,
   output busPkg::byteSel_t  wbSel,
   output rvPkg::word_t      wbWriteData,
   input  rvPkg::word_t      wbReadData,
   input  logic              wbAck
);
   import rvPkg::*;
   import busPkg::*;

   typedef enum logic {
      busIdle,
      busAck
   } busState_t;

   busState_t state;
   // High for the one cycle after an ack, keeps the bus idle
   logic      busGap;
   logic      memOp;
   word_t     byteLane;
   word_t     halfLane;
   word_t     loadData;

   assign memOp = rsValid && (rsMemRead || rsMemWrite);

   // Cycle opens in the same clock the access reaches this stage
   assign wbCyc       = (state == busAck) || (memOp && !busGap);
   assign wbStb       = wbCyc;
   assign wbWe        = wbCyc && rsMemWrite;
   assign wbAdr       = {rsAlu[31:2], 2'b00};
   assign wbSel       = rsByteSel;
   assign wbWriteData = rsStoreData;

   // Whole core waits until the access is acknowledged
   assign stall = memOp && !(wbCyc && wbAck);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state  <= busIdle;
         busGap <= 1'b0;
      end
      else
      begin
         busGap <= wbCyc && wbAck;
         case (state)
            busIdle: if (wbCyc && !wbAck) state <= busAck;
            busAck:  if (wbAck) state <= busIdle;
            default: state <= busIdle;
         endcase
      end
   end

   // Misaligned halves fall back to the aligned lane pair
   assign byteLane = wbReadData >> {rsAlu[1:0], 3'b000};
   assign halfLane = rsAlu[1] ? {16'b0, wbReadData[31:16]} : {16'b0, wbReadData[15:0]};

   always_comb
   begin
      case (rsMemSize)
         sizeByte: loadData = rsMemUnsigned ? {24'b0, byteLane[7:0]}
                                            : {{24{byteLane[7]}}, byteLane[7:0]};
         sizeHalf: loadData = rsMemUnsigned ? {16'b0, halfLane[15:0]}
                                            : {{16{halfLane[15]}}, halfLane[15:0]};
         default:  loadData = wbReadData;
      endcase
   end

   always_comb
   begin
      case (rsResultSel)
         resMem:  wrData = loadData;
         resLink: wrData = rsLink;
         default: wrData = rsAlu;
      endcase
   end

   // A load writes on its ack edge, when stall drops
   assign wrEnable = rsValid && rsRegWrite && !stall;
   assign wrAddr   = rsRd;

   assign fwdValid = wrEnable;
   assign fwdRd    = rsRd;
   assign fwdData  = wrData;

endmodule

//--- src/riscvCore.sv
`timescale 1ns/10ps

module riscvCore #(
   parameter rvPkg::word_t resetAddr = 32'h0000_0000
) (
   input  logic             clk,
   input  logic             rst,
   output rvPkg::word_t     instrAddr,
   input  rvPkg::word_t     instrData,
   output logic             wbCyc,
   output logic             wbStb,
   output logic             wbWe,
   output rvPkg::word_t     wbAdr,
   output busPkg::byteSel_t wbSel,
   output rvPkg::word_t     wbWriteData,
   input  rvPkg::word_t     wbReadData,
   input  logic             wbAck
);
   import rvPkg::*;
   import busPkg::*;

   // Register file read and write ports
   regAddr_t   rdAddrA;
   regAddr_t   rdAddrB;
   word_t      rdDataA;
   word_t      rdDataB;
   logic       wrEnable;
   regAddr_t   wrAddr;
   word_t      wrData;

   // Back-channels
   logic       stall;
   logic       redirect;
   word_t      redirectPc;
   logic       fwdValid;
   regAddr_t   fwdRd;
   word_t      fwdData;

   // Decode to execute
   logic       exValid;
   word_t      exPc;
   regAddr_t   exRs1;
   regAddr_t   exRs2;
   word_t      exRs1Data;
   word_t      exRs2Data;
   word_t      exImm;
   aluOp_t     exAluOp;
   logic       exUseImm;
   logic       exUsePc;
   resultSel_t exResultSel;
   regAddr_t   exRd;
   logic       exRegWrite;
   logic       exIsBranch;
   logic [2:0] exBranchCond;
   logic       exIsJal;
   logic       exIsJalr;
   logic       exMemRead;
   logic       exMemWrite;
   memSize_t   exMemSize;
   logic       exMemUnsigned;

   // Execute to result
   logic       rsValid;
   regAddr_t   rsRd;
   logic       rsRegWrite;
   resultSel_t rsResultSel;
   word_t      rsAlu;
   word_t      rsLink;
   logic       rsMemRead;
   logic       rsMemWrite;
   memSize_t   rsMemSize;
   logic       rsMemUnsigned;
   word_t      rsStoreData;
   byteSel_t   rsByteSel;

   regFile regs (.*);

   decodeStage #(
      .resetAddr(resetAddr)
   ) decode (.*);

   executeStage execute (.*);

   resultStage result (.*);

endmodule

//--- bench/coreTb_assert.sv
`timescale 1ns/10ps

module busProtocolChecks (
   input logic             clk,
   input logic             rst,
   input logic             wbCyc,
   input logic             wbStb,
   input logic             wbWe,
   input rvPkg::word_t     wbAdr,
   input busPkg::byteSel_t wbSel,
   input rvPkg::word_t     wbWriteData,
   input logic             wbAck
);

   // Strobe only inside a bus cycle
   stbInsideCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
      else $error("wbStb high without wbCyc");

   // Request held unchanged until the slave acknowledges
   requestStable: assert property (@(posedge clk) disable iff (rst)
      (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr) && $stable(wbWe) &&
                             $stable(wbSel) && $stable(wbWriteData)))
      else $error("Wishbone request changed or dropped before wbAck");

   selNonZero: assert property (@(posedge clk) disable iff (rst) wbCyc |-> (wbSel != 4'b0000))
      else $error("wbSel is zero during a bus cycle");

   idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !wbCyc)
      else $error("wbCyc high in the first cycle after reset");

endmodule

bind riscvCore busProtocolChecks busChecks (
   .clk(clk),
   .rst(rst),
   .wbCyc(wbCyc),
   .wbStb(wbStb),
   .wbWe(wbWe),
   .wbAdr(wbAdr),
   .wbSel(wbSel),
   .wbWriteData(wbWriteData),
   .wbAck(wbAck)
);

//--- bench/coreTb.sv
`timescale 1ns/10ps

module coreTb;
   import rvPkg::*;
   import busPkg::*;

   localparam word_t resetAddr  = 32'h0000_0000;
   // Every result store lands in this word
   localparam word_t resultAddr = 32'h0000_1000;
   // A store here ends the program
   localparam word_t doneAddr   = 32'h0000_1100;

   logic     clk;
   logic     rst;
   word_t    instrAddr;
   word_t    instrData;
   logic     wbCyc;
   logic     wbStb;
   logic     wbWe;
   word_t    wbAdr;
   byteSel_t wbSel;
   word_t    wbWriteData;
   word_t    wbReadData;
   logic     wbAck;

   word_t    rom [1024];
   word_t    dmem [4096];
   int       progLen;
   word_t    rngState;

   // Expected stores in program order
   word_t    expData [$];
   byteSel_t expSel [$];
   string    expName [$];

   riscvCore #(
      .resetAddr(resetAddr)
   ) dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic word_t nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   // Preset data memory contents mixing every address bit
   function automatic word_t patternWord(input word_t addr);
      return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5;
   endfunction

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      assert (actual === expected)
      else failRun($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
   endtask

   // RV32I ALU rules
   function automatic word_t aluRef(input aluOp_t op, input word_t a, input word_t b);
      case (op)
         aluAdd:  return a + b;
         aluSub:  return a - b;
         aluSll:  return a << b[4:0];
         aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         aluSltu: return (a < b) ? 32'd1 : 32'd0;
         aluXor:  return a ^ b;
         aluSrl:  return a >> b[4:0];
         aluSra:  return word_t'($signed(a) >>> b[4:0]);
         aluOr:   return a | b;
         aluAnd:  return a & b;
         default: return b;
      endcase
   endfunction

   function automatic logic branchRef(input int f3, input word_t a, input word_t b);
      case (f3)
         0:       return a == b;
         1:       return a != b;
         4:       return $signed(a) < $signed(b);
         5:       return !($signed(a) < $signed(b));
         6:       return a < b;
         default: return !(a < b);
      endcase
   endfunction

   // {funct7 bit 30, funct3}
   function automatic logic [3:0] functOf(input aluOp_t op);
      case (op)
         aluSub:  return 4'b1000;
         aluSll:  return 4'b0001;
         aluSlt:  return 4'b0010;
         aluSltu: return 4'b0011;
         aluXor:  return 4'b0100;
         aluSrl:  return 4'b0101;
         aluSra:  return 4'b1101;
         aluOr:   return 4'b0110;
         aluAnd:  return 4'b0111;
         default: return 4'b0000;
      endcase
   endfunction

   function automatic word_t encR(input int f7, input int rs2, input int rs1, input int f3,
                                  input int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opOp};
   endfunction

   function automatic word_t encI(input word_t imm, input int rs1, input int f3, input int rd,
                                  input opcode_t op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction

   function automatic word_t encS(input word_t imm, input int rs2, input int rs1, input int f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
   endfunction

   function automatic word_t encB(input word_t imm, input int rs2, input int rs1, input int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
   endfunction

   // Upper 20 bits of imm land in the instruction
   function automatic word_t encU(input word_t imm, input int rd, input opcode_t op);
      return {imm[31:12], rd[4:0], op};
   endfunction

   function automatic word_t encJ(input word_t imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
   endfunction

   function automatic word_t nextPc();
      return resetAddr + (word_t'(progLen) << 2);
   endfunction

   task automatic emit(input word_t instr);
      rom[progLen] = instr;
      progLen = progLen + 1;
   endtask

   task automatic pad(input int n);
      for (int i = 0; i < n; i++)
         emit(encI(32'd0, 0, 0, 0, opOpImm));
   endtask

   task automatic expectStore(input string name, input word_t data, input byteSel_t sel);
      expName.push_back(name);
      expData.push_back(data);
      expSel.push_back(sel);
   endtask

   // x31 holds the result area base
   task automatic storeWord(input int rs, input string name, input word_t value);
      emit(encS(32'd0, rs, 31, 2));
      expectStore(name, value, 4'b1111);
   endtask

   // LUI plus an ADDI that depends on the LUI right before it
   task automatic loadConst(input int rd, input word_t value);
      emit(encU(value + 32'h800, rd, opLui));
      emit(encI(value, rd, 0, rd, opOpImm));
   endtask

   task automatic buildAluTests(input int gap);
      aluOp_t     op;
      logic [3:0] fn;
      word_t      a;
      word_t      b;
      word_t      imm;
      word_t      pcNow;
      for (int k = 0; k < 10; k++)
      begin
         op = aluOp_t'(k[3:0]);
         fn = functOf(op);
         a  = nextRandom();
         b  = nextRandom();
         loadConst(1, a);
         loadConst(2, b);
         pad(gap);
         emit(encR({25'b0, 1'b0, fn[3], 5'b0}, 2, 1, {29'b0, fn[2:0]}, 3));
         pad(gap);
         if (op != aluSub)
         begin
            imm = nextRandom();
            if (fn[1:0] == 2'b01)
               imm = {20'b0, 1'b0, fn[3], 5'b0, imm[4:0]};
            else
               imm = {{20{imm[11]}}, imm[11:0]};
            emit(encI(imm, 1, {29'b0, fn[2:0]}, 4, opOpImm));
            pad(gap);
         end
         // With no gap the stores read results written two slots earlier
         storeWord(3, $sformatf("%s reg gap %0d", op.name(), gap), aluRef(op, a, b));
         if (op != aluSub)
            storeWord(4, $sformatf("%s imm gap %0d", op.name(), gap), aluRef(op, a, imm));
      end
      b = nextRandom() & 32'hffff_f000;
      emit(encU(b, 5, opLui));
      pad(gap);
      storeWord(5, $sformatf("lui gap %0d", gap), b);
      pcNow = nextPc();
      emit(encU(b, 6, opAuipc));
      pad(gap);
      storeWord(6, $sformatf("auipc gap %0d", gap), pcNow + b);
   endtask

   // Loads from the preset area at x30 stored back as words and narrow lanes
   task automatic buildMemTests();
      word_t w;
      word_t v;
      int    lane;
      emit(encU(32'h0000_2000, 30, opLui));
      for (int off = 0; off < 8; off++)
      begin
         lane = off % 4;
         w = patternWord(32'h2000 + word_t'(off - lane));
         v = w >> (8 * lane);
         emit(encI(word_t'(off), 30, 0, 7, opLoad));
         storeWord(7, $sformatf("lb offset %0d", off), {{24{v[7]}}, v[7:0]});
         emit(encI(word_t'(off), 30, 4, 7, opLoad));
         storeWord(7, $sformatf("lbu offset %0d", off), {24'b0, v[7:0]});
         emit(encS(word_t'(lane), 7, 31, 0));
         expectStore($sformatf("sb lane %0d", lane), {4{v[7:0]}}, 4'b0001 << lane);
         if (lane % 2 == 0)
         begin
            emit(encI(word_t'(off), 30, 1, 7, opLoad));
            storeWord(7, $sformatf("lh offset %0d", off), {{16{v[15]}}, v[15:0]});
            emit(encI(word_t'(off), 30, 5, 7, opLoad));
            storeWord(7, $sformatf("lhu offset %0d", off), {16'b0, v[15:0]});
            emit(encS(word_t'(lane), 7, 31, 1));
            expectStore($sformatf("sh lane %0d", lane), {2{v[15:0]}},
                        (lane == 2) ? 4'b1100 : 4'b0011);
         end
         if (lane == 0)
         begin
            emit(encI(word_t'(off), 30, 2, 7, opLoad));
            storeWord(7, $sformatf("lw offset %0d", off), w);
         end
      end
   endtask

   // A taken branch skips the store of x9 and a not-taken one falls into it
   task automatic buildBranchTests();
      word_t a;
      word_t b;
      word_t x;
      word_t y;
      int    f3;
      int    idx;
      string name;
      for (int c = 0; c < 6; c++)
      begin
         f3 = (c < 2) ? c : c + 2;
         for (int v = 0; v < 3; v++)
         begin
            a    = nextRandom();
            b    = nextRandom();
            x    = (v == 1) ? b : a;
            y    = (v == 0) ? b : a;
            idx  = c * 3 + v;
            name = $sformatf("branch f3 %0d case %0d", f3, v);
            loadConst(1, x);
            loadConst(2, y);
            emit(encI(32'h100 + word_t'(idx), 0, 0, 9, opOpImm));
            emit(encB(32'd8, 2, 1, f3));
            emit(encS(32'd0, 9, 31, 2));
            if (!branchRef(f3, x, y))
               expectStore({name, " fall-through"}, 32'h100 + word_t'(idx), 4'b1111);
            emit(encI(32'h200 + word_t'(idx), 0, 0, 9, opOpImm));
            storeWord(9, {name, " target"}, 32'h200 + word_t'(idx));
         end
      end
   endtask

   task automatic buildJumpTests();
      word_t base;
      loadConst(10, 32'hdead_beef);
      base = nextPc();
      emit(encJ(32'd8, 13));
      emit(encS(32'd0, 10, 31, 2));
      storeWord(13, "jal link", base + 32'd4);
      // Odd JALR offset so bit 0 of the target gets cleared
      base = nextPc();
      emit(encU(32'd0, 14, opAuipc));
      emit(encI(32'd13, 14, 0, 15, opJalr));
      emit(encS(32'd0, 10, 31, 2));
      storeWord(15, "jalr link", base + 32'd8);
   endtask

   task automatic applyReset();
      rst = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      checkWord("reset fetch address", resetAddr, instrAddr);
      checkWord("reset bus idle", 32'd0, {29'b0, wbCyc, wbStb, wbWe});
   endtask

   // Synchronous-read ROM with one cycle of latency
   task automatic runRom();
      word_t addr;
      forever
      begin
         @(posedge clk);
         addr = instrAddr;
         #1;
         instrData = rom[addr[11:2]];
      end
   endtask

   task automatic handleWrite(input word_t adr, input byteSel_t sel, input word_t data);
      word_t mask;
      string name;
      word_t expected;
      word_t expectedSel;
      mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
      if (adr == doneAddr)
      begin
         if (expData.size() == 0)
         begin
            $display("TEST RESULT: PASS");
            $finish;
         end
         else
         begin
            failRun($sformatf("Done store reached with %0d expected stores never seen",
                              expData.size()));
         end
      end
      else
      begin
         assert (expData.size() != 0)
         else failRun("A store appeared after every expected store had been seen");
         name        = expName.pop_front();
         expected    = expData.pop_front();
         expectedSel = word_t'(expSel.pop_front());
         checkWord({name, " address"}, resultAddr, adr);
         checkWord({name, " byte select"}, expectedSel, word_t'(sel));
         checkWord(name, expected & mask, data & mask);
         dmem[adr[13:2]] = (dmem[adr[13:2]] & ~mask) | (data & mask);
      end
   endtask

   // Wishbone slave with a random wait of 0 to 3 cycles before each ack
   task automatic runBusSlave();
      logic     req;
      logic     we;
      logic     ackSeen;
      word_t    adr;
      byteSel_t sel;
      word_t    data;
      word_t    ackWait;
      ackWait = nextRandom() % 4;
      forever
      begin
         @(posedge clk);
         req     = wbCyc && wbStb;
         we      = wbWe;
         adr     = wbAdr;
         sel     = wbSel;
         data    = wbWriteData;
         ackSeen = wbAck;
         #1;
         if (ackSeen)
         begin
            wbAck = 1'b0;
         end
         else if (req && ackWait != 0)
         begin
            ackWait = ackWait - 1;
         end
         else if (req)
         begin
            wbAck   = 1'b1;
            ackWait = nextRandom() % 4;
            if (we)
               handleWrite(adr, sel, data);
            else
               wbReadData = dmem[adr[13:2]];
         end
      end
   endtask

   task automatic runWatchdog();
      repeat (20 * progLen + 10) @(posedge clk);
      failRun("Watchdog expired before the program reached its done store");
   endtask

   initial
   begin
      rst        = 1'b1;
      instrData  = '0;
      wbReadData = '0;
      wbAck      = 1'b0;
      rngState   = 32'h0d90_afe1;
      progLen    = 0;
      for (int i = 0; i < 1024; i++)
         rom[i] = '0;
      for (int i = 0; i < 4096; i++)
         dmem[i] = patternWord(word_t'(i) << 2);

      emit(encU(resultAddr, 31, opLui));
      buildAluTests(3);
      // Same operations back to back through forwarding and write-through
      buildAluTests(0);
      buildMemTests();
      buildBranchTests();
      buildJumpTests();
      emit(encS(doneAddr - resultAddr, 0, 31, 2));

      fork
         applyReset();
         runRom();
         runBusSlave();
         runWatchdog();
      join
   end

endmodule

//--- filelist.f
src/rvPkg.sv
src/busPkg.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/riscvCore.sv
bench/coreTb_assert.sv
bench/coreTb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module coreTb -o coreSim &&
./obj_dir/coreSim || exit 1
